// ==== build.f ====
+incdir+hdl
hdl/audio_pkg.sv
hdl/cmd_port.sv
hdl/sample_stabilizer.sv
hdl/channel_mixer.sv
hdl/audio_mix_top.sv
testbench/tb_audio_mix.sv

// ==== hdl/audio_mix_top.sv ====
/* Stereo mixing path on a single clock. Core samples have no handshake and are
   filtered before mixing; outputs are valid every cycle, with no back-pressure. */
`timescale 1ns/1ps
`default_nettype none

module audio_mix_top (
	input  wire                    clk,
	input  wire                    resetd,
	input  wire                    io_uio_i,
	input  wire                    io_strobe_i,
	input  wire [15:0]             io_din_i,
	input  audio_pkg::sample_t     core_l_i,
	input  audio_pkg::sample_t     core_r_i,
	input  audio_pkg::sample_t     linux_l_i,
	input  audio_pkg::sample_t     linux_r_i,
	input  wire                    is_signed_i,
	input  audio_pkg::mix_mode_t   mix_i,
	output wire                    io_ack_o,
	output audio_pkg::sample_t     audio_l_o,
	output audio_pkg::sample_t     audio_r_o
);

	audio_pkg::att_t    vol_att;
	audio_pkg::sample_t core_l_stable;
	audio_pkg::sample_t core_r_stable;
	audio_pkg::sample_t pre_l;
	audio_pkg::sample_t pre_r;

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	cmd_port u_cmd_port (
		.clk         (clk),
		.resetd      (resetd),
		.io_uio_i    (io_uio_i),
		.io_strobe_i (io_strobe_i),
		.io_din_i    (io_din_i),
		.io_ack_o    (io_ack_o),
		.vol_att_o   (vol_att)
	);

	//////////////////////////////////////////////////
	// Left and right channels
	//////////////////////////////////////////////////

	sample_stabilizer u_stab_l (
		.clk      (clk),
		.resetd   (resetd),
		.sample_i (core_l_i),
		.sample_o (core_l_stable)
	);

	sample_stabilizer u_stab_r (
		.clk      (clk),
		.resetd   (resetd),
		.sample_i (core_r_i),
		.sample_o (core_r_stable)
	);

	// Each mixer takes the other's pre value for cross-feed
	channel_mixer u_mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.sample_i    (core_l_stable),
		.linux_i     (linux_l_i),
		.pre_i       (pre_r),
		.is_signed_i (is_signed_i),
		.mix_i       (mix_i),
		.att_i       (vol_att),
		.pre_o       (pre_l),
		.out_o       (audio_l_o)
	);

	channel_mixer u_mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.sample_i    (core_r_stable),
		.linux_i     (linux_r_i),
		.pre_i       (pre_l),
		.is_signed_i (is_signed_i),
		.mix_i       (mix_i),
		.att_i       (vol_att),
		.pre_o       (pre_r),
		.out_o       (audio_r_o)
	);

endmodule

`default_nettype wire

// ==== hdl/audio_pkg.sv ====
/* Shared types of the stereo mixing path. Widths come from audio_settings.svh,
   which must be on the include path. */
`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

	// Signed PCM sample as seen on every audio port
	typedef logic signed [`AUDIO_W-1:0] sample_t;

	// Mixer intermediate with one bit of headroom
	typedef logic signed [`ACC_W-1:0] acc_t;

	// Top bit mutes, low bits give the right shift
	typedef logic [`ATT_W-1:0] att_t;

	// Share of the other channel fed into each output
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_HIGH = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

endpackage

`default_nettype wire

// ==== hdl/audio_settings.svh ====
/* Widths and command codes for the audio mixing path.
   ACC_W must be AUDIO_W + 1; ATT_W keeps mute in its top bit. */
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

//////////////////////////////////////////////////
// Sample path widths
//////////////////////////////////////////////////

// PCM sample width at every port
`define AUDIO_W 16

// One headroom bit for the sum of core and Linux samples
`define ACC_W 17

// Attenuation field, mute flag on top, shift amount below
`define ATT_W 5

//////////////////////////////////////////////////
// Host command codes and filtering
//////////////////////////////////////////////////

`define CMD_VOLUME 8'h26

// Delay stages in front of the stabilizer compare
`define STABLE_DEPTH 3

`endif

// ==== hdl/channel_mixer.sv ====
/* One channel of the mixer, five register stages with pre_o at stage 3.
   Cross-feed input pre_i is the other channel's pre_o; result saturates to 16 bits. */
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module channel_mixer (
	input  wire                    clk,
	input  wire                    resetd,
	input  audio_pkg::sample_t     sample_i,
	input  audio_pkg::sample_t     linux_i,
	input  audio_pkg::sample_t     pre_i,
	input  wire                    is_signed_i,
	input  audio_pkg::mix_mode_t   mix_i,
	input  audio_pkg::att_t        att_i,
	output audio_pkg::sample_t     pre_o,
	output audio_pkg::sample_t     out_o
);

	audio_pkg::acc_t linux_ext;
	audio_pkg::acc_t pre_ext;
	audio_pkg::acc_t conv_q;
	audio_pkg::acc_t sum_q;
	audio_pkg::acc_t mix_q;
	audio_pkg::acc_t att_q;
	logic            clip;

	assign linux_ext = {linux_i[`AUDIO_W-1], linux_i};
	assign pre_ext   = {pre_i[`AUDIO_W-1], pre_i};

	// Top two bits differ when the value leaves the 16 bit range
	assign clip = att_q[`ACC_W-1] ^ att_q[`ACC_W-2];

	//////////////////////////////////////////////////
	// Stages 1 and 2, widen and add Linux PCM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			conv_q <= '0;
			sum_q  <= '0;
		end else begin
			// Unsigned core audio is halved so it lands in the signed range
			if (is_signed_i) begin
				conv_q <= {sample_i[`AUDIO_W-1], sample_i};
			end else begin
				conv_q <= {2'b00, sample_i[`AUDIO_W-1:1]};
			end
			sum_q <= conv_q + linux_ext;
		end
	end

	//////////////////////////////////////////////////
	// Stage 3, cross-feed
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			pre_o <= '0;
			mix_q <= '0;
		end else begin
			pre_o <= sum_q[`ACC_W-1:1];
			case (mix_i)
				audio_pkg::MIX_NONE: mix_q <= sum_q;
				audio_pkg::MIX_LOW:  mix_q <= sum_q - (sum_q >>> 3) + (pre_ext >>> 2);
				audio_pkg::MIX_HIGH: mix_q <= sum_q - (sum_q >>> 2) + (pre_ext >>> 1);
				audio_pkg::MIX_MONO: mix_q <= (sum_q >>> 1) + pre_ext;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Stages 4 and 5, attenuate and clamp
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			att_q <= '0;
			out_o <= '0;
		end else begin
			if (att_i[`ATT_W-1]) begin
				att_q <= '0;
			end else begin
				att_q <= mix_q >>> att_i[`ATT_W-2:0];
			end
			if (clip) begin
				out_o <= {att_q[`ACC_W-1], {(`AUDIO_W-1){~att_q[`ACC_W-1]}}};
			end else begin
				out_o <= att_q[`AUDIO_W-1:0];
			end
		end
	end

	// Mute has reached the output once it has crossed stages 4 and 5
	a_mute_silences : assert property (
		@(posedge clk) disable iff (resetd)
		att_i[`ATT_W-1] [*5] |=> (out_o == '0)
	);

endmodule

`default_nettype wire

// ==== hdl/cmd_port.sv ====
/* Host command port. Strobe must be synchronous to clk; only the volume
   command (0x26) is decoded, every other command's data words are dropped. */
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module cmd_port (
	input  wire                  clk,
	input  wire                  resetd,
	input  wire                  io_uio_i,
	input  wire                  io_strobe_i,
	input  wire [15:0]           io_din_i,
	output logic                 io_ack_o,
	output audio_pkg::att_t      vol_att_o
);

	logic       strobe_d;
	logic       strobe_rise;
	logic       has_cmd;
	logic [7:0] cmd;

	assign strobe_rise = io_strobe_i & ~strobe_d;

	//////////////////////////////////////////////////
	// Strobe edge and acknowledge chain
	//////////////////////////////////////////////////

	// Ack trails the strobe by two registers
	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_d <= 1'b0;
			io_ack_o <= 1'b0;
		end else begin
			strobe_d <= io_strobe_i;
			io_ack_o <= strobe_d;
		end
	end

	//////////////////////////////////////////////////
	// Command decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= 8'h00;
			vol_att_o <= '0;
		end else if (!io_uio_i) begin
			// Dropping uio ends the transfer
			has_cmd <= 1'b0;
			cmd     <= 8'h00;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				// First word of a transfer is the command
				has_cmd <= 1'b1;
				cmd     <= io_din_i[7:0];
			end else if (cmd == `CMD_VOLUME) begin
				vol_att_o <= io_din_i[`ATT_W-1:0];
			end
		end
	end

	// Volume moves only in the cycle after a strobe edge at the port
	a_vol_after_strobe : assert property (
		@(posedge clk) disable iff (resetd)
		$changed(vol_att_o) |-> $past(io_strobe_i) && !$past(io_strobe_i, 2)
	);

	// No acknowledge leaks out while in reset
	a_ack_low_in_reset : assert property (
		@(posedge clk)
		resetd |=> !io_ack_o
	);

endmodule

`default_nettype wire

// ==== hdl/sample_stabilizer.sv ====
/* Glitch filter for core samples. A value shows up 3 cycles after it is sampled
   and only if it held for two cycles; shorter pulses never pass. */
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module sample_stabilizer (
	input  wire                  clk,
	input  wire                  resetd,
	input  audio_pkg::sample_t   sample_i,
	output audio_pkg::sample_t   sample_o
);

	audio_pkg::sample_t dly_q [`STABLE_DEPTH];

	always_ff @(posedge clk) begin
		if (resetd) begin
			for (int i = 0; i < `STABLE_DEPTH; i++) begin
				dly_q[i] <= '0;
			end
			sample_o <= '0;
		end else begin
			dly_q[0] <= sample_i;
			for (int i = 1; i < `STABLE_DEPTH; i++) begin
				dly_q[i] <= dly_q[i-1];
			end
			// Last two taps agreeing means the value settled
			if (dly_q[`STABLE_DEPTH-2] == dly_q[`STABLE_DEPTH-1]) begin
				sample_o <= dly_q[`STABLE_DEPTH-2];
			end
		end
	end

	// A new output was seen on the input two cycles in a row
	a_held_only_when_stable : assert property (
		@(posedge clk) disable iff (resetd)
		$changed(sample_o) |->
			(sample_o == $past(sample_i, 3)) && (sample_o == $past(sample_i, 4))
	);

endmodule

`default_nettype wire

// ==== testbench/tb_audio_mix.sv ====
/* Testbench for the stereo mixing path. Outputs are checked by concurrent assertions
   once inputs and volume have been steady for 12 cycles; inputs change on falling edges. */
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module tb_audio_mix;

	localparam int SETTLE_CYCLES = 12;
	localparam int CHECK_CYCLES  = 4;
	localparam int ACK_TIMEOUT   = 20;

	logic                 clk;
	logic                 resetd;
	logic                 io_uio_i;
	logic                 io_strobe_i;
	logic [15:0]          io_din_i;
	audio_pkg::sample_t   core_l_i;
	audio_pkg::sample_t   core_r_i;
	audio_pkg::sample_t   linux_l_i;
	audio_pkg::sample_t   linux_r_i;
	logic                 is_signed_i;
	audio_pkg::mix_mode_t mix_i;
	logic                 io_ack_o;
	audio_pkg::sample_t   audio_l_o;
	audio_pkg::sample_t   audio_r_o;

	logic                 reset_chk;
	logic                 steady_chk;
	audio_pkg::sample_t   exp_l;
	audio_pkg::sample_t   exp_r;
	audio_pkg::att_t      vol_model;
	logic [31:0]          lfsr_q;

	audio_mix_top dut (
		.clk         (clk),
		.resetd      (resetd),
		.io_uio_i    (io_uio_i),
		.io_strobe_i (io_strobe_i),
		.io_din_i    (io_din_i),
		.core_l_i    (core_l_i),
		.core_r_i    (core_r_i),
		.linux_l_i   (linux_l_i),
		.linux_r_i   (linux_r_i),
		.is_signed_i (is_signed_i),
		.mix_i       (mix_i),
		.io_ack_o    (io_ack_o),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// Random source and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic audio_pkg::sample_t random_sample();
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			value  = {value[14:0], lfsr_q[0]};
		end
		return value;
	endfunction

	// Core sample widened, plus the Linux sample
	function automatic audio_pkg::acc_t channel_sum(input audio_pkg::sample_t core,
		input audio_pkg::sample_t linux, input logic is_signed);
		int conv;
		if (is_signed) begin
			conv = int'(core);
		end else begin
			conv = int'($unsigned(core)) / 2;
		end
		return audio_pkg::acc_t'(conv + int'(linux));
	endfunction

	function automatic int channel_out(input int sum_self, input int pre_other,
		input audio_pkg::mix_mode_t mix, input audio_pkg::att_t att);
		int mixed;
		int scaled;
		case (mix)
			audio_pkg::MIX_LOW:  mixed = sum_self - (sum_self >>> 3) + (pre_other >>> 2);
			audio_pkg::MIX_HIGH: mixed = sum_self - (sum_self >>> 2) + (pre_other >>> 1);
			audio_pkg::MIX_MONO: mixed = (sum_self >>> 1) + pre_other;
			default:             mixed = sum_self;
		endcase
		if (att[`ATT_W-1]) begin
			scaled = 0;
		end else begin
			scaled = mixed >>> att[`ATT_W-2:0];
		end
		if (scaled > 32767) begin
			return 32767;
		end
		if (scaled < -32768) begin
			return -32768;
		end
		return scaled;
	endfunction

	// Steady state of both channels, each pre value taken from its own sum
	function automatic logic [31:0] model_stereo(input audio_pkg::sample_t cl,
		input audio_pkg::sample_t cr, input audio_pkg::sample_t ll,
		input audio_pkg::sample_t lr, input logic is_signed,
		input audio_pkg::mix_mode_t mix, input audio_pkg::att_t att);
		audio_pkg::acc_t sum_l;
		audio_pkg::acc_t sum_r;
		int              out_l;
		int              out_r;
		sum_l = channel_sum(cl, ll, is_signed);
		sum_r = channel_sum(cr, lr, is_signed);
		out_l = channel_out(int'(sum_l), int'(sum_r >>> 1), mix, att);
		out_r = channel_out(int'(sum_r), int'(sum_l >>> 1), mix, att);
		return {out_l[15:0], out_r[15:0]};
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_reset_outputs : assert property (@(posedge clk)
		reset_chk |-> (audio_l_o == '0 && audio_r_o == '0 && io_ack_o == 1'b0))
		else fail_now($sformatf("mismatch after reset audio_l_o=%h audio_r_o=%h io_ack_o=%h",
			$sampled(audio_l_o), $sampled(audio_r_o), $sampled(io_ack_o)));

	a_left_steady : assert property (@(posedge clk) steady_chk |-> (audio_l_o == exp_l))
		else fail_now($sformatf("mismatch audio_l_o got %h expected %h",
			$sampled(audio_l_o), $sampled(exp_l)));

	a_right_steady : assert property (@(posedge clk) steady_chk |-> (audio_r_o == exp_r))
		else fail_now($sformatf("mismatch audio_r_o got %h expected %h",
			$sampled(audio_r_o), $sampled(exp_r)));

	a_ack_follows_strobe : assert property (@(posedge clk) disable iff (resetd)
		io_ack_o == $past(io_strobe_i, 2))
		else fail_now($sformatf("mismatch io_ack_o got %h expected %h",
			$sampled(io_ack_o), $past(io_strobe_i, 2)));

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (io_ack_o !== level && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (io_ack_o !== level) begin
			fail_now("timed out waiting for io_ack_o to follow io_strobe_i");
		end
	endtask

	task automatic send_word(input logic [15:0] data);
		@(negedge clk);
		io_din_i    = data;
		io_strobe_i = 1'b1;
		wait_ack(1'b1);
		io_strobe_i = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic send_command(input logic [7:0] cmd, input logic [15:0] data);
		@(negedge clk);
		io_uio_i = 1'b1;
		send_word({8'h00, cmd});
		send_word(data);
		@(negedge clk);
		io_uio_i = 1'b0;
		if (cmd == `CMD_VOLUME) begin
			vol_model = data[`ATT_W-1:0];
		end
	endtask

	task automatic apply_steady(input audio_pkg::sample_t cl, input audio_pkg::sample_t cr,
		input audio_pkg::sample_t ll, input audio_pkg::sample_t lr, input logic is_signed,
		input audio_pkg::mix_mode_t mix);
		logic [31:0] expected;
		@(negedge clk);
		core_l_i    = cl;
		core_r_i    = cr;
		linux_l_i   = ll;
		linux_r_i   = lr;
		is_signed_i = is_signed;
		mix_i       = mix;
		expected    = model_stereo(cl, cr, ll, lr, is_signed, mix, vol_model);
		exp_l       = expected[31:16];
		exp_r       = expected[15:0];
		repeat (SETTLE_CYCLES) @(negedge clk);
		steady_chk = 1'b1;
		repeat (CHECK_CYCLES) @(negedge clk);
		steady_chk = 1'b0;
	endtask

	task automatic apply_random(input logic is_signed, input audio_pkg::mix_mode_t mix);
		audio_pkg::sample_t cl;
		audio_pkg::sample_t cr;
		audio_pkg::sample_t ll;
		audio_pkg::sample_t lr;
		cl = random_sample();
		cr = random_sample();
		ll = random_sample();
		lr = random_sample();
		apply_steady(cl, cr, ll, lr, is_signed, mix);
	endtask

	// Output stays on its steady value across a one-cycle spike on the left core
	task automatic glitch_left();
		audio_pkg::sample_t held;
		apply_random(1'b1, audio_pkg::MIX_LOW);
		held       = core_l_i;
		steady_chk = 1'b1;
		@(negedge clk);
		core_l_i = ~held;
		@(negedge clk);
		core_l_i = held;
		repeat (SETTLE_CYCLES) @(negedge clk);
		steady_chk = 1'b0;
	endtask

	initial begin
		resetd      = 1'b1;
		io_uio_i    = 1'b0;
		io_strobe_i = 1'b0;
		io_din_i    = '0;
		core_l_i    = '0;
		core_r_i    = '0;
		linux_l_i   = '0;
		linux_r_i   = '0;
		is_signed_i = 1'b1;
		mix_i       = audio_pkg::MIX_NONE;
		reset_chk   = 1'b0;
		steady_chk  = 1'b0;
		exp_l       = '0;
		exp_r       = '0;
		vol_model   = '0;
		lfsr_q      = 32'h1f3dcfef;

		repeat (16) @(negedge clk);
		resetd    = 1'b0;
		reset_chk = 1'b1;
		repeat (4) @(negedge clk);
		reset_chk = 1'b0;

		// Attenuation shift, no cross-feed
		send_command(`CMD_VOLUME, 16'h0002);
		repeat (3) apply_random(1'b1, audio_pkg::MIX_NONE);

		// Cross-feed modes, unsigned then signed core samples
		send_command(`CMD_VOLUME, 16'h0000);
		apply_random(1'b0, audio_pkg::MIX_LOW);
		apply_random(1'b1, audio_pkg::MIX_LOW);
		apply_random(1'b0, audio_pkg::MIX_HIGH);
		apply_random(1'b1, audio_pkg::MIX_HIGH);
		apply_random(1'b0, audio_pkg::MIX_MONO);
		apply_random(1'b1, audio_pkg::MIX_MONO);

		// Saturation both ways, then mute
		apply_steady(16'h7000, 16'h7800, 16'h7000, 16'h6000, 1'b1, audio_pkg::MIX_NONE);
		apply_steady(16'h9000, 16'h8800, 16'h9000, 16'h8000, 1'b1, audio_pkg::MIX_NONE);
		send_command(`CMD_VOLUME, 16'h0010);
		apply_random(1'b1, audio_pkg::MIX_MONO);

		// Foreign command must not touch the volume
		send_command(`CMD_VOLUME, 16'h0001);
		send_command(8'h27, 16'h0010);
		apply_random(1'b1, audio_pkg::MIX_HIGH);

		glitch_left();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
